// File: hw/colmix_pkg.sv
// Colour mixer shared types
`default_nettype none

package colmix_pkg;

    // Scroll pixel {group[1:0], colour[4:0], pen[3:0]}
    typedef logic [10:0] scr_pxl_t;

    // Object or star pixel {colour[4:0], pen[3:0]}
    typedef logic [8:0] spr_pxl_t;

    // Layer tag, top bits of the palette index
    typedef logic [2:0] lyr_code_t;

    // Queue entry {group[1:0], tag[2:0], pixel[8:0]}
    typedef logic [13:0] tagged_pxl_t;

    // Palette index {tag[2:0], pixel[8:0]}
    typedef logic [11:0] pal_idx_t;

    // Palette word {bright[15:12], red[11:8], green[7:4], blue[3:0]}
    typedef logic [15:0] pal_word_t;

    // Output colour channel
    typedef logic [7:0] chan_t;

    // Layer tags
    localparam lyr_code_t LYR_OBJ  = 3'd0;
    localparam lyr_code_t LYR_SCR1 = 3'd1;
    localparam lyr_code_t LYR_SCR2 = 3'd2;
    localparam lyr_code_t LYR_SCR3 = 3'd3;
    localparam lyr_code_t LYR_STAR = 3'd4;

    // Pen value that lets lower layers show through
    localparam logic [3:0] TRANSPARENT_PEN = 4'hF;

    // Index for a fully transparent pixel, carried with group 3
    localparam pal_idx_t BLANK_IDX = 12'hBFF;

endpackage

`default_nettype wire

// File: hw/colmix.sv
// Layer priority mixer
`timescale 1ns/1ps
`default_nettype none

module colmix
    import colmix_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         pxl_cen,

    input  wire  [3:0]  gfx_en,

    input  wire scr_pxl_t scr1_pxl,
    input  wire scr_pxl_t scr2_pxl,
    input  wire scr_pxl_t scr3_pxl,
    input  wire spr_pxl_t star0_pxl,
    input  wire spr_pxl_t star1_pxl,
    input  wire spr_pxl_t obj_pxl,

    input  wire  [15:0] layer_ctrl,
    input  wire  [3:1]  scrdma_en,
    input  wire  [7:0]  layer_mask0,
    input  wire  [7:0]  layer_mask1,
    input  wire  [7:0]  layer_mask2,
    input  wire  [7:0]  layer_mask3,
    input  wire  [7:0]  layer_mask4,
    input  wire  [15:0] prio0,
    input  wire  [15:0] prio1,
    input  wire  [15:0] prio2,
    input  wire  [15:0] prio3,

    output pal_idx_t    idx,
    output logic        idx_valid
);

    // Filler entry once the real slots are used up
    localparam tagged_pxl_t BLANK_ENTRY = {2'b11, BLANK_IDX};

    // Force pen to transparent when the layer is off
    function automatic scr_pxl_t gate_scr(scr_pxl_t p, logic on);
        return on ? p : {p[10:4], TRANSPARENT_PEN};
    endfunction

    function automatic spr_pxl_t gate_spr(spr_pxl_t p, logic on);
        return on ? p : {p[8:4], TRANSPARENT_PEN};
    endfunction

    // Scroll keeps its group, objects and stars sit in group 0
    function automatic tagged_pxl_t tag_scr(scr_pxl_t p, lyr_code_t code);
        return {p[10:9], code, p[8:0]};
    endfunction

    function automatic tagged_pxl_t tag_spr(spr_pxl_t p, lyr_code_t code);
        return {2'b00, code, p};
    endfunction

    logic [4:0]   lyr_en;
    tagged_pxl_t  lyr_opt [4];
    tagged_pxl_t  star0_ent;
    tagged_pxl_t  star1_ent;
    tagged_pxl_t  queue [5];
    tagged_pxl_t  head;
    logic [1:0]   cand_grp;
    pal_idx_t     cand;
    logic         check_prio;
    logic         primed;
    logic [15:0]  prio_sel;
    logic         obj_loses;
    logic         take;

    // Mask enables, bits 0..2 scroll, 3..4 stars
    assign lyr_en[0] = |(layer_mask0[5:0] & layer_ctrl[5:0]);
    assign lyr_en[1] = |(layer_mask1[5:0] & layer_ctrl[5:0]);
    assign lyr_en[2] = |(layer_mask2[5:0] & layer_ctrl[5:0]);
    assign lyr_en[3] = |(layer_mask3[5:0] & layer_ctrl[5:0]);
    assign lyr_en[4] = |(layer_mask4[5:0] & layer_ctrl[5:0]);

    // Selectable layers, indexed by the 2-bit order field
    // Object layer only follows its graphics enable
    assign lyr_opt[0] = tag_spr(gate_spr(obj_pxl, gfx_en[3]), LYR_OBJ);
    assign lyr_opt[1] = tag_scr(gate_scr(scr1_pxl, lyr_en[0] & scrdma_en[1] & gfx_en[0]),
                                LYR_SCR1);
    assign lyr_opt[2] = tag_scr(gate_scr(scr2_pxl, lyr_en[1] & scrdma_en[2] & gfx_en[1]),
                                LYR_SCR2);
    assign lyr_opt[3] = tag_scr(gate_scr(scr3_pxl, lyr_en[2] & scrdma_en[3] & gfx_en[2]),
                                LYR_SCR3);

    // Star fields always fill the two bottom slots
    assign star0_ent = tag_spr(gate_spr(star0_pxl, lyr_en[3]), LYR_STAR);
    assign star1_ent = tag_spr(gate_spr(star1_pxl, lyr_en[4]), LYR_STAR);

    // Entry on offer this cycle
    assign head = queue[0];

    // Priority mask of the current candidate's group
    always_comb begin
        case (cand_grp)
            2'd0:    prio_sel = prio0;
            2'd1:    prio_sel = prio1;
            2'd2:    prio_sel = prio2;
            default: prio_sel = prio3;
        endcase
    end

    // Object stays behind a scroll pen flagged in the mask
    assign obj_loses = (head[11:9] == LYR_OBJ) && check_prio && prio_sel[cand[3:0]];

    // Transparent candidate always gives way
    assign take = (cand[3:0] == TRANSPARENT_PEN) ||
                  ((head[3:0] != TRANSPARENT_PEN) && !obj_loses);

    // Control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            check_prio <= 1'b0;
            primed     <= 1'b0;
            idx_valid  <= 1'b0;
        end else begin
            // First strobe only loads the candidate
            idx_valid <= pxl_cen & primed;
            if (pxl_cen) begin
                primed     <= 1'b1;
                // Star start never holds priority
                check_prio <= 1'b0;
            end else if (take) begin
                check_prio <= (head[11:9] != LYR_STAR);
            end
        end
    end

    // Slot load, candidate scan and output register
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            idx               <= cand;
            {cand_grp, cand}  <= star1_ent;
            // Offered from slot 4 down to slot 0
            queue[0]          <= star0_ent;
            queue[1]          <= lyr_opt[layer_ctrl[7:6]];
            queue[2]          <= lyr_opt[layer_ctrl[9:8]];
            queue[3]          <= lyr_opt[layer_ctrl[11:10]];
            queue[4]          <= lyr_opt[layer_ctrl[13:12]];
        end else begin
            if (take) begin
                {cand_grp, cand} <= head;
            end
            // Shift in blanks behind the last slot
            for (int i = 0; i < 4; i++) begin
                queue[i] <= queue[i+1];
            end
            queue[4] <= BLANK_ENTRY;
        end
    end

endmodule

`default_nettype wire

// File: hw/pxl_fifo.sv
// Palette index FIFO
`timescale 1ns/1ps
`default_nettype none

module pxl_fifo
    import colmix_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           push,
    input  wire pal_idx_t wr_idx,
    input  wire           pop,
    output pal_idx_t      rd_idx,
    output logic          empty
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    pal_idx_t        mem [FIFO_DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            full;
    logic            do_wr;
    logic            do_rd;

    assign empty = (count == '0);
    assign full  = (count == CW'(FIFO_DEPTH));

    // Push on full is lost, pop on empty ignored
    assign do_wr = push & ~full;
    assign do_rd = pop & ~empty;

    // Head word shows without a read request
    assign rd_idx = mem[rd_ptr];

    // Pointers wrap at the depth, not a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_idx;
        end
    end

endmodule

`default_nettype wire

// File: hw/palette_lookup.sv
// Palette RAM and RGB output
`timescale 1ns/1ps
`default_nettype none

module palette_lookup
    import colmix_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,

    // FIFO read side
    input  wire            empty,
    input  wire pal_idx_t  rd_idx,
    output logic           pop,

    // CPU palette write
    input  wire            pal_we,
    input  wire pal_idx_t  pal_addr,
    input  wire pal_word_t pal_data,

    // Video out
    output logic           rgb_valid,
    output chan_t          red,
    output chan_t          green,
    output chan_t          blue
);

    // 4-bit colour scaled by brightness + 1, max 15 x 16
    function automatic chan_t scale(logic [3:0] c, logic [3:0] bright);
        chan_t c_w;
        chan_t b_w;
        c_w = {4'h0, c};
        b_w = {4'h0, bright} + 8'd1;
        return c_w * b_w;
    endfunction

    pal_word_t pal_ram [4096];
    pal_word_t rd_word;
    logic      rd_valid;

    // CPU write owns the RAM port, lookup waits
    assign pop = ~empty & ~pal_we;

    // Single port RAM, write first
    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_ram[pal_addr] <= pal_data;
        end else if (pop) begin
            rd_word <= pal_ram[rd_idx];
        end
    end

    // Strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid  <= 1'b0;
            rgb_valid <= 1'b0;
        end else begin
            rd_valid  <= pop;
            rgb_valid <= rd_valid;
        end
    end

    // Colour channels, one cycle after RAM data
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            red   <= scale(rd_word[11:8], rd_word[15:12]);
            green <= scale(rd_word[7:4],  rd_word[15:12]);
            blue  <= scale(rd_word[3:0],  rd_word[15:12]);
        end
    end

endmodule

`default_nettype wire

// File: hw/colmix_top.sv
// Colour mixer top level
`timescale 1ns/1ps
`default_nettype none

module colmix_top
    import colmix_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            pxl_cen,

    input  wire  [3:0]     gfx_en,

    // Layer pixels
    input  wire scr_pxl_t  scr1_pxl,
    input  wire scr_pxl_t  scr2_pxl,
    input  wire scr_pxl_t  scr3_pxl,
    input  wire spr_pxl_t  star0_pxl,
    input  wire spr_pxl_t  star1_pxl,
    input  wire spr_pxl_t  obj_pxl,

    // Layer control registers
    input  wire  [15:0]    layer_ctrl,
    input  wire  [3:1]     scrdma_en,
    input  wire  [7:0]     layer_mask0,
    input  wire  [7:0]     layer_mask1,
    input  wire  [7:0]     layer_mask2,
    input  wire  [7:0]     layer_mask3,
    input  wire  [7:0]     layer_mask4,
    input  wire  [15:0]    prio0,
    input  wire  [15:0]    prio1,
    input  wire  [15:0]    prio2,
    input  wire  [15:0]    prio3,

    // CPU palette port
    input  wire            pal_we,
    input  wire pal_idx_t  pal_addr,
    input  wire pal_word_t pal_data,

    // RGB out
    output logic           rgb_valid,
    output chan_t          red,
    output chan_t          green,
    output chan_t          blue
);

    pal_idx_t idx;
    logic     idx_valid;
    pal_idx_t rd_idx;
    logic     empty;
    logic     pop;

    // Priority resolution, one index per pixel
    colmix u_mix (
        .clk         (clk),
        .rst_n       (rst_n),
        .pxl_cen     (pxl_cen),
        .gfx_en      (gfx_en),
        .scr1_pxl    (scr1_pxl),
        .scr2_pxl    (scr2_pxl),
        .scr3_pxl    (scr3_pxl),
        .star0_pxl   (star0_pxl),
        .star1_pxl   (star1_pxl),
        .obj_pxl     (obj_pxl),
        .layer_ctrl  (layer_ctrl),
        .scrdma_en   (scrdma_en),
        .layer_mask0 (layer_mask0),
        .layer_mask1 (layer_mask1),
        .layer_mask2 (layer_mask2),
        .layer_mask3 (layer_mask3),
        .layer_mask4 (layer_mask4),
        .prio0       (prio0),
        .prio1       (prio1),
        .prio2       (prio2),
        .prio3       (prio3),
        .idx         (idx),
        .idx_valid   (idx_valid)
    );

    // Buffer across palette write stalls
    pxl_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .push   (idx_valid),
        .wr_idx (idx),
        .pop    (pop),
        .rd_idx (rd_idx),
        .empty  (empty)
    );

    // Lookup and brightness
    palette_lookup u_pal (
        .clk       (clk),
        .rst_n     (rst_n),
        .empty     (empty),
        .rd_idx    (rd_idx),
        .pop       (pop),
        .pal_we    (pal_we),
        .pal_addr  (pal_addr),
        .pal_data  (pal_data),
        .rgb_valid (rgb_valid),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

`default_nettype wire

// File: testbench/colmix_checker.sv
// Mixer strobe assertions
`timescale 1ns/1ps
`default_nettype none

module colmix_checker (
    input wire clk,
    input wire rst_n,
    input wire push,
    input wire pop,
    input wire empty,
    input wire full,
    input wire blocked
);

    // A push on full would drop a pixel index
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("index pushed while the FIFO is full");

    // Pop only with a word at the head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("pop from an empty FIFO");

    // Palette write holds off the lookup
    a_no_pop_blocked: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !blocked)
        else $error("lookup issued during a palette write");

    // Strobes known once out of reset
    a_known: assert property (@(posedge clk) disable iff (!rst_n)
                              !$isunknown({push, pop, empty}))
        else $error("FIFO strobe unknown after reset");

endmodule

`default_nettype wire

// File: testbench/colmix_tb.sv
// Colour mixer testbench
`timescale 1ns/1ps
`default_nettype none

module colmix_tb
    import colmix_pkg::*;
();

    localparam int PER     = 40;
    localparam int NPIX    = 8 + 5 * PER;
    // Palette load, then 8 clk per pixel plus slack
    localparam int TIMEOUT = 4096 + (NPIX + 4) * 8 + 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        pxl_cen;
    logic [3:0]  gfx_en;
    scr_pxl_t    scr_pxl [3];
    spr_pxl_t    star0_pxl;
    spr_pxl_t    star1_pxl;
    spr_pxl_t    obj_pxl;
    logic [15:0] layer_ctrl;
    logic [3:1]  scrdma_en;
    logic [7:0]  layer_mask [5];
    logic [15:0] prio [4];
    logic        pal_we;
    pal_idx_t    pal_addr;
    pal_word_t   pal_data;
    logic        rgb_valid;
    chan_t       red;
    chan_t       green;
    chan_t       blue;

    logic [31:0] lfsr = 32'h767d;
    pal_word_t   pal_model [4096];
    pal_idx_t    exp_q [$];
    pal_idx_t    look_q [$];
    pal_idx_t    got_idx;
    int          n_done = 0;
    int          cycles = 0;

    // Recent pxl_cen and pal_we, one bit per falling edge
    logic [3:0]  cen_hist   = '0;
    logic [3:0]  we_hist    = '0;
    logic        cen_before = 1'b0;

    always #2 clk = ~clk;

    colmix_top #(.FIFO_DEPTH(8)) uut (
        .*,
        .scr1_pxl    (scr_pxl[0]),
        .scr2_pxl    (scr_pxl[1]),
        .scr3_pxl    (scr_pxl[2]),
        .layer_mask0 (layer_mask[0]),
        .layer_mask1 (layer_mask[1]),
        .layer_mask2 (layer_mask[2]),
        .layer_mask3 (layer_mask[3]),
        .layer_mask4 (layer_mask[4]),
        .prio0       (prio[0]),
        .prio1       (prio[1]),
        .prio2       (prio[2]),
        .prio3       (prio[3])
    );

    // FIFO side and palette side share one checker
    bind pxl_fifo colmix_checker u_fifo_chk (
        .clk(clk), .rst_n(rst_n), .push(push), .pop(pop),
        .empty(empty), .full(full), .blocked(1'b0)
    );
    bind palette_lookup colmix_checker u_pal_chk (
        .clk(clk), .rst_n(rst_n), .push(1'b0), .pop(pop),
        .empty(empty), .full(1'b0), .blocked(pal_we)
    );

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // Opaque only in the ordering test
    function automatic logic [3:0] rand_pen(input int mode, input logic clear);
        logic [3:0] p;
        p = 4'(take_bits(4));
        return clear ? 4'hF : ((mode == 2 && p == 4'hF) ? 4'h0 : p);
    endfunction

    // Expected index from enable, order and replacement rules
    function automatic pal_idx_t mix_ref();
        tagged_pxl_t opt [4];
        tagged_pxl_t offer [6];
        logic [4:0]  en;
        logic [15:0] pm;
        pal_idx_t    cand;
        logic [1:0]  grp;
        logic        guard;
        logic        obj_loses;
        for (int k = 0; k < 5; k++) begin
            en[k] = |(layer_mask[k][5:0] & layer_ctrl[5:0]);
        end
        opt[0] = {2'b00, LYR_OBJ, obj_pxl[8:4], gfx_en[3] ? obj_pxl[3:0] : 4'hF};
        for (int k = 0; k < 3; k++) begin
            opt[k+1] = {scr_pxl[k][10:9], lyr_code_t'(k + 1), scr_pxl[k][8:4],
                        (en[k] && scrdma_en[k+1] && gfx_en[k]) ? scr_pxl[k][3:0] : 4'hF};
        end
        // Offer sequence, slot 4 first, blank last
        offer[0] = {2'b00, LYR_STAR, star0_pxl[8:4], en[3] ? star0_pxl[3:0] : 4'hF};
        offer[1] = opt[layer_ctrl[7:6]];
        offer[2] = opt[layer_ctrl[9:8]];
        offer[3] = opt[layer_ctrl[11:10]];
        offer[4] = opt[layer_ctrl[13:12]];
        offer[5] = {2'b11, BLANK_IDX};
        // Star field 1 starts as candidate
        cand  = {LYR_STAR, star1_pxl[8:4], en[4] ? star1_pxl[3:0] : 4'hF};
        grp   = 2'd0;
        guard = 1'b0;
        for (int s = 0; s < 6; s++) begin
            pm        = prio[grp];
            obj_loses = (offer[s][11:9] == LYR_OBJ) && guard && pm[cand[3:0]];
            if ((cand[3:0] == 4'hF) || ((offer[s][3:0] != 4'hF) && !obj_loses)) begin
                cand  = offer[s][11:0];
                grp   = offer[s][13:12];
                guard = (offer[s][11:9] != LYR_STAR);
            end
        end
        return cand;
    endfunction

    // Channel times brightness + 1, ch 2 red, 1 green, 0 blue
    function automatic chan_t rgb_ref(input pal_idx_t i, input int ch);
        pal_word_t w;
        int        c;
        w = pal_model[i];
        c = int'((w >> (4 * ch)) & 16'hF);
        return chan_t'(c * (int'(w[15:12]) + 1));
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_idx(input string name, input pal_idx_t want, input pal_idx_t got);
        if (got !== want) begin
            abort_run($sformatf("FAIL %s expected 0x%h got 0x%h", name, want, got));
        end
    endtask

    task automatic check_chan(input string name, input chan_t want, input chan_t got);
        if (got !== want) begin
            abort_run($sformatf("FAIL %s expected 0x%h got 0x%h", name, want, got));
        end
    endtask

    task automatic check_strobe(input string name, input logic want, input logic got);
        if (got !== want) begin
            abort_run($sformatf("FAIL %s expected 0x%h got 0x%h", name, want, got));
        end
    endtask

    // Whole RAM gets random words
    task automatic load_palette();
        pal_word_t w;
        for (int a = 0; a < 4096; a++) begin
            @(posedge clk);
            w            = 16'(take_bits(16));
            pal_model[a] = w;
            pal_we      <= 1'b1;
            pal_addr    <= pal_idx_t'(a);
            pal_data    <= w;
        end
        @(posedge clk);
        pal_we <= 1'b0;
    endtask

    // One pixel per 8 clk, mode 0 only flushes the last result
    task automatic drive_pixel(input int mode, input int stall);
        logic [15:0] ctrl;
        logic        clear;
        pal_idx_t    addr;
        @(posedge clk);
        ctrl  = (mode == 1) ? 16'h1B3F : 16'(take_bits(16));
        clear = (mode == 3) && (take_bits(2) == 32'd0);
        layer_ctrl <= (mode < 5) ? {ctrl[15:6], 6'h3F} : ctrl;
        gfx_en     <= (mode < 5) ? 4'hF : 4'(take_bits(4));
        scrdma_en  <= (mode < 5) ? 3'h7 : 3'(take_bits(3));
        for (int k = 0; k < 5; k++) begin
            layer_mask[k] <= (mode < 5) ? 8'hFF : 8'(take_bits(8));
        end
        for (int k = 0; k < 4; k++) begin
            prio[k] <= (mode < 4) ? 16'h0 : 16'(take_bits(16));
        end
        if (mode == 1) begin
            scr_pxl[0] <= 11'h123;
            scr_pxl[1] <= 11'h2A5;
            scr_pxl[2] <= 11'h3C7;
            star0_pxl  <= 9'h0A1;
            star1_pxl  <= 9'h1B2;
            obj_pxl    <= 9'h0F3;
        end else if (mode > 1) begin
            for (int k = 0; k < 3; k++) begin
                scr_pxl[k] <= {7'(take_bits(7)), rand_pen(mode, clear)};
            end
            star0_pxl <= {5'(take_bits(5)), rand_pen(mode, clear)};
            star1_pxl <= {5'(take_bits(5)), rand_pen(mode, clear)};
            obj_pxl   <= {5'(take_bits(5)), rand_pen(mode, clear)};
        end
        pxl_cen <= 1'b1;
        @(posedge clk);
        pxl_cen <= 1'b0;
        if (mode != 0) begin
            exp_q.push_back(mix_ref());
        end
        // Write burst puts back the model word, so lookups only stall
        addr = 12'(take_bits(12));
        for (int i = 2; i < 8; i++) begin
            pal_we   <= (i - 2) < stall;
            pal_addr <= addr;
            pal_data <= pal_model[addr];
            @(posedge clk);
        end
        pal_we <= 1'b0;
    endtask

    // Compare process on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (uut.idx_valid && exp_q.size() == 0) begin
                abort_run("index output with no pixel pending");
            end else if (uut.idx_valid) begin
                got_idx = exp_q.pop_front();
                check_idx("idx", got_idx, uut.idx);
                look_q.push_back(got_idx);
            end
            if (rgb_valid && look_q.size() == 0) begin
                abort_run("rgb output with no index pending");
            end else if (rgb_valid) begin
                got_idx = look_q.pop_front();
                check_chan("red", rgb_ref(got_idx, 2), red);
                check_chan("green", rgb_ref(got_idx, 1), green);
                check_chan("blue", rgb_ref(got_idx, 0), blue);
                n_done++;
            end
            // RGB 4 clk after a pxl_cen that closes a pixel, unless a write stalled it
            if (we_hist == 4'h0) begin
                check_strobe("rgb_valid", cen_hist[3] && cen_before, rgb_valid);
            end
            cen_before = cen_before | cen_hist[3];
            cen_hist   = {cen_hist[2:0], pxl_cen};
            we_hist    = {we_hist[2:0], pal_we};
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            abort_run("timeout: rgb output stopped");
        end
    end

    initial begin
        rst_n      = 1'b0;
        pxl_cen    = 1'b0;
        gfx_en     = 4'h0;
        scr_pxl    = '{default: '0};
        star0_pxl  = '0;
        star1_pxl  = '0;
        obj_pxl    = '0;
        layer_ctrl = 16'h0;
        scrdma_en  = 3'h0;
        layer_mask = '{default: '0};
        prio       = '{default: '0};
        pal_we     = 1'b0;
        pal_addr   = '0;
        pal_data   = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        load_palette();
        repeat (8) drive_pixel(1, 0);
        // Ordering, transparency, priority, disable
        for (int m = 2; m <= 5; m++) begin
            repeat (PER) drive_pixel(m, 0);
        end
        repeat (PER) drive_pixel(6, int'(take_bits(2)));
        drive_pixel(0, 0);
        wait (n_done == NPIX);
        repeat (4) @(posedge clk);
        if (exp_q.size() == 0 && look_q.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            abort_run("results left over after the last pixel");
        end
    end

endmodule

`default_nettype wire

// File: all.f
hw/colmix_pkg.sv
hw/colmix.sv
hw/pxl_fifo.sv
hw/palette_lookup.sv
hw/colmix_top.sv
testbench/colmix_checker.sv
testbench/colmix_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module colmix_tb -f all.f -o colmix_sim
	out=$$(./obj_dir/colmix_sim 2>&1); echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir
